// File: Makefile
VERILATOR ?= verilator
TOP       ?= vout_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '\*\* PASS \*\*' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
+incdir+source
source/vout_pkg.sv
source/fb_port_if.sv
source/fb_arbiter.sv
source/capture_writer.sv
source/scanout_fetch.sv
source/video_timing_out.sv
source/vout_top.sv
testbench/vout_chk.sv
testbench/vout_tb.sv

// File: source/capture_writer.sv
// Capture writer
// Queues incoming pixels and stores them at sequential frame addresses
`timescale 1ns/1ps
`include "vout_params.svh"

module capture_writer (
  input  logic             HDMI_CLK_w,
  input  logic             HDMI_nRST_w,
  input  logic             cap_valid_i,
  input  logic             cap_sof_i,
  input  vout_pkg::pixel_t cap_pixel_i,
  fb_port_if.master        fb
);

  import vout_pkg::*;

  localparam int QW = $clog2(`VOUT_WQ_DEPTH);
  localparam logic [QW:0] Q_FULL = (QW+1)'(`VOUT_WQ_DEPTH);
  localparam fb_addr_t LAST_ADDR = fb_addr_t'(`VOUT_FRAME_PIXELS - 1);

  fb_addr_t        q_addr [`VOUT_WQ_DEPTH];
  pixel_t          q_pix  [`VOUT_WQ_DEPTH];
  logic [QW-1:0]   head_q;
  logic [QW-1:0]   tail_q;
  logic [QW:0]     count_q;
  fb_addr_t        wr_addr_q;
  fb_addr_t        in_addr;
  logic            push;
  logic            pop;

  // Start of frame restarts at word 0
  assign in_addr = cap_sof_i ? '0 : wr_addr_q;
  assign push    = cap_valid_i && (count_q != Q_FULL);
  assign pop     = fb.req && fb.gnt;

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      wr_addr_q <= '0;
      head_q    <= '0;
      tail_q    <= '0;
      count_q   <= '0;
    end else begin
      if (push) begin
        wr_addr_q <= (in_addr == LAST_ADDR) ? '0 : in_addr + 1'b1;
        tail_q    <= tail_q + 1'b1;
      end
      if (pop)
        head_q <= head_q + 1'b1;
      // Occupancy
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Queue storage
  always_ff @(posedge HDMI_CLK_w) begin
    if (push) begin
      q_addr[tail_q] <= in_addr;
      q_pix[tail_q]  <= cap_pixel_i;
    end
  end

  // Head held as write request until granted
  assign fb.req   = (count_q != '0);
  assign fb.we    = 1'b1;
  assign fb.addr  = q_addr[head_q];
  assign fb.wdata = q_pix[head_q];

endmodule

// File: source/fb_arbiter.sv
// Frame buffer arbiter
// Owns the single-port frame memory, round-robin between two peer ports
`timescale 1ns/1ps
`include "vout_params.svh"

module fb_arbiter (
  input  logic       HDMI_CLK_w,
  input  logic       HDMI_nRST_w,
  fb_port_if.arbiter wr_port,
  fb_port_if.arbiter rd_port
);

  import vout_pkg::*;

  pixel_t     mem [`VOUT_FRAME_PIXELS];
  arb_state_e last_q;

  logic     gnt_wr;
  logic     gnt_rd;
  logic     any_gnt;
  logic     sel_we;
  fb_addr_t sel_addr;
  pixel_t   sel_wdata;
  pixel_t   rdata_q;
  logic     rvalid_wr_q;
  logic     rvalid_rd_q;

  ////////////////////////////////////////////////////////////
  // Grant, combinational in the request cycle

  always_comb begin
    gnt_wr = 1'b0;
    gnt_rd = 1'b0;
    if (wr_port.req && rd_port.req) begin
      // Both asking, the port not served last wins
      if (last_q == GRANT_WR)
        gnt_rd = 1'b1;
      else
        gnt_wr = 1'b1;
    end else begin
      gnt_wr = wr_port.req;
      gnt_rd = rd_port.req;
    end
  end

  assign any_gnt   = gnt_wr | gnt_rd;
  assign sel_we    = gnt_wr ? wr_port.we    : rd_port.we;
  assign sel_addr  = gnt_wr ? wr_port.addr  : rd_port.addr;
  assign sel_wdata = gnt_wr ? wr_port.wdata : rd_port.wdata;

  assign wr_port.gnt = gnt_wr;
  assign rd_port.gnt = gnt_rd;

  ////////////////////////////////////////////////////////////
  // Round-robin state and read valid

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      last_q      <= GRANT_RD;
      rvalid_wr_q <= 1'b0;
      rvalid_rd_q <= 1'b0;
    end else begin
      if (gnt_wr)
        last_q <= GRANT_WR;
      else if (gnt_rd)
        last_q <= GRANT_RD;
      // Only the master that read sees rvalid
      rvalid_wr_q <= gnt_wr & ~wr_port.we;
      rvalid_rd_q <= gnt_rd & ~rd_port.we;
    end
  end

  // Memory access of the granted master
  always_ff @(posedge HDMI_CLK_w) begin
    if (any_gnt) begin
      if (sel_we)
        mem[sel_addr] <= sel_wdata;
      else
        rdata_q <= mem[sel_addr];
    end
  end

  // Read data shared, qualified per port by rvalid
  assign wr_port.rdata  = rdata_q;
  assign rd_port.rdata  = rdata_q;
  assign wr_port.rvalid = rvalid_wr_q;
  assign rd_port.rvalid = rvalid_rd_q;

endmodule

// File: source/fb_port_if.sv
// Frame buffer port of one master
// Request side from the master, grant and read return from the arbiter
`timescale 1ns/1ps

interface fb_port_if;
  import vout_pkg::*;

  // Master side
  logic     req;
  logic     we;
  fb_addr_t addr;
  pixel_t   wdata;

  // Arbiter side
  logic     gnt;
  logic     rvalid;
  pixel_t   rdata;

  // Accepted on req && gnt, read data one cycle later
  modport master (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

// File: source/scanout_fetch.sv
// Scanout fetcher
// Credit-limited frame buffer reads in raster order, returned pixels pushed on
`timescale 1ns/1ps
`include "vout_params.svh"

module scanout_fetch (
  input  logic              HDMI_CLK_w,
  input  logic              HDMI_nRST_w,
  input  logic              scan_en_i,
  input  logic              credit_ret_i,
  fb_port_if.master         fb,
  output logic              pix_push_o,
  output vout_pkg::pixel_t  pix_o
);

  import vout_pkg::*;

  localparam credit_t  CREDIT_MAX = credit_t'(`VOUT_FIFO_DEPTH);
  localparam fb_addr_t LAST_ADDR  = fb_addr_t'(`VOUT_FRAME_PIXELS - 1);

  fb_addr_t rd_addr_q;
  credit_t  credits_q;
  logic     rd_accept;

  // Ask only with a credit in hand
  assign fb.req    = scan_en_i && (credits_q != '0);
  assign fb.we     = 1'b0;
  assign fb.addr   = rd_addr_q;
  assign fb.wdata  = '0;
  assign rd_accept = fb.req && fb.gnt;

  ////////////////////////////////////////////////////////////
  // Address and credit bookkeeping

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      rd_addr_q <= '0;
      credits_q <= CREDIT_MAX;
    end else if (!scan_en_i) begin
      // Idle, back to frame start with a full FIFO worth of credits
      rd_addr_q <= '0;
      credits_q <= CREDIT_MAX;
    end else begin
      if (rd_accept)
        rd_addr_q <= (rd_addr_q == LAST_ADDR) ? '0 : rd_addr_q + 1'b1;
      // One credit per accepted read, one back per FIFO pop
      case ({rd_accept, credit_ret_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  // Read return goes straight to the FIFO
  // Late return after disable dropped
  assign pix_push_o = fb.rvalid && scan_en_i;
  assign pix_o      = fb.rdata;

endmodule

// File: source/video_timing_out.sv
// Video timing and output stage
// Raster counters, pixel FIFO with credit return, registered sync, DE and RGB
// Each line and frame begins with blanking, the active area comes last
`timescale 1ns/1ps
`include "vout_params.svh"

module video_timing_out (
  input  logic             HDMI_CLK_w,
  input  logic             HDMI_nRST_w,
  input  logic             scan_en_i,
  input  logic             pix_push_i,
  input  vout_pkg::pixel_t pix_i,
  output logic             credit_ret_o,
  output logic             HSYNC_o,
  output logic             VSYNC_o,
  output logic             DE_o,
  output vout_pkg::pixel_t VD_o,
  output logic             underrun_o
);

  import vout_pkg::*;

  localparam int PW = $clog2(`VOUT_FIFO_DEPTH);
  localparam credit_t FIFO_FULL = credit_t'(`VOUT_FIFO_DEPTH);

  // Line: front porch, sync, back porch, active
  localparam hcnt_t H_SYNC_BEG = hcnt_t'(`VOUT_H_FRONT);
  localparam hcnt_t H_SYNC_END = hcnt_t'(`VOUT_H_FRONT + `VOUT_H_SYNC);
  localparam hcnt_t H_ACT_BEG  = hcnt_t'(`VOUT_H_FRONT + `VOUT_H_SYNC + `VOUT_H_BACK);
  localparam hcnt_t H_LAST     = hcnt_t'(`VOUT_H_TOTAL - 1);
  // Frame: front porch line, sync line, active lines
  localparam vcnt_t V_SYNC_BEG = vcnt_t'(`VOUT_V_FRONT);
  localparam vcnt_t V_ACT_BEG  = vcnt_t'(`VOUT_V_FRONT + `VOUT_V_SYNC);
  localparam vcnt_t V_LAST     = vcnt_t'(`VOUT_V_TOTAL - 1);

  hcnt_t         hcnt_q;
  vcnt_t         vcnt_q;
  logic          hsync_c;
  logic          vsync_c;
  logic          de_c;
  pixel_t        fifo_mem [`VOUT_FIFO_DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  credit_t       fifo_cnt_q;
  logic          fifo_empty;
  logic          push;
  logic          pop;

  ////////////////////////////////////////////////////////////
  // Raster counters and timing decode

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      hcnt_q <= '0;
      vcnt_q <= '0;
    end else if (!scan_en_i) begin
      hcnt_q <= '0;
      vcnt_q <= '0;
    end else if (hcnt_q == H_LAST) begin
      hcnt_q <= '0;
      vcnt_q <= (vcnt_q == V_LAST) ? '0 : vcnt_q + 1'b1;
    end else begin
      hcnt_q <= hcnt_q + 1'b1;
    end
  end

  assign hsync_c = (hcnt_q >= H_SYNC_BEG) && (hcnt_q < H_SYNC_END);
  assign vsync_c = (vcnt_q >= V_SYNC_BEG) && (vcnt_q < V_ACT_BEG);
  assign de_c    = scan_en_i && (hcnt_q >= H_ACT_BEG) && (vcnt_q >= V_ACT_BEG);

  ////////////////////////////////////////////////////////////
  // Pixel FIFO, one pop and one credit per DE cycle

  assign fifo_empty   = (fifo_cnt_q == '0);
  assign push         = pix_push_i && scan_en_i && (fifo_cnt_q != FIFO_FULL);
  assign pop          = de_c && !fifo_empty;
  assign credit_ret_o = pop;

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else if (!scan_en_i) begin
      // Flush
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: fifo_cnt_q <= fifo_cnt_q;
      endcase
    end
  end

  always_ff @(posedge HDMI_CLK_w) begin
    if (push)
      fifo_mem[wr_ptr_q] <= pix_i;
  end

  ////////////////////////////////////////////////////////////
  // Output registers, one cycle behind the counters

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      HSYNC_o    <= 1'b0;
      VSYNC_o    <= 1'b0;
      DE_o       <= 1'b0;
      VD_o       <= '0;
      underrun_o <= 1'b0;
    end else if (!scan_en_i) begin
      HSYNC_o    <= 1'b0;
      VSYNC_o    <= 1'b0;
      DE_o       <= 1'b0;
      VD_o       <= '0;
      underrun_o <= 1'b0;
    end else begin
      HSYNC_o <= hsync_c;
      VSYNC_o <= vsync_c;
      DE_o    <= de_c;
      // Blank or starved pixels show black
      VD_o    <= pop ? fifo_mem[rd_ptr_q] : '0;
      // Sticky until scanout is disabled
      if (de_c && fifo_empty)
        underrun_o <= 1'b1;
    end
  end

endmodule

// File: source/vout_params.svh
// Video output path parameters
// Raster geometry, pixel FIFO depth and frame buffer size
`ifndef VOUT_PARAMS_SVH
`define VOUT_PARAMS_SVH

// Horizontal timing in pixel clocks
`define VOUT_H_ACTIVE 8
`define VOUT_H_FRONT  1
`define VOUT_H_SYNC   2
`define VOUT_H_BACK   1
`define VOUT_H_TOTAL  (`VOUT_H_FRONT + `VOUT_H_SYNC + `VOUT_H_BACK + `VOUT_H_ACTIVE)

// Vertical timing in lines
`define VOUT_V_ACTIVE 4
`define VOUT_V_FRONT  1
`define VOUT_V_SYNC   1
`define VOUT_V_TOTAL  (`VOUT_V_FRONT + `VOUT_V_SYNC + `VOUT_V_ACTIVE)

// Buffer sizes in words
`define VOUT_FRAME_PIXELS 32
`define VOUT_FIFO_DEPTH   8
`define VOUT_WQ_DEPTH     4

`endif

// File: source/vout_pkg.sv
// Video output path types
// Pixel, address, credit and raster counter types plus FSM states
package vout_pkg;

  // 24 bit RGB, 8 bits per colour
  typedef logic [23:0] pixel_t;

  // Frame buffer word address, 32 words
  typedef logic [4:0] fb_addr_t;

  // Credits, 0 up to the FIFO depth
  typedef logic [3:0] credit_t;

  // Raster counters
  typedef logic [3:0] hcnt_t;
  typedef logic [2:0] vcnt_t;

  // Last master served by the arbiter
  typedef enum logic {
    GRANT_WR,
    GRANT_RD
  } arb_state_e;

endpackage

// File: source/vout_top.sv
// HDMI video output path
// Capture writer and scanout fetcher share the frame buffer, output stage drives the raster
`timescale 1ns/1ps

module vout_top (
  input  logic        HDMI_CLK_w,
  input  logic        HDMI_nRST_w,
  input  logic        scan_en_i,
  input  logic        cap_valid_i,
  input  logic        cap_sof_i,
  input  logic [23:0] cap_pixel_i,
  output logic        HSYNC_o,
  output logic        VSYNC_o,
  output logic        DE_o,
  output logic [23:0] VD_o,
  output logic        underrun_o
);

  import vout_pkg::*;

  // Fetcher to output stage
  logic   pix_push_w;
  pixel_t pix_w;
  logic   credit_ret_w;

  // One frame buffer port per master
  fb_port_if wr_if ();
  fb_port_if rd_if ();

  ////////////////////////////////////////////////////////////
  // Frame buffer and its two masters

  fb_arbiter fb_arbiter_u (
    .HDMI_CLK_w (HDMI_CLK_w),
    .HDMI_nRST_w(HDMI_nRST_w),
    .wr_port    (wr_if.arbiter),
    .rd_port    (rd_if.arbiter)
  );

  capture_writer capture_writer_u (
    .HDMI_CLK_w (HDMI_CLK_w),
    .HDMI_nRST_w(HDMI_nRST_w),
    .cap_valid_i(cap_valid_i),
    .cap_sof_i  (cap_sof_i),
    .cap_pixel_i(cap_pixel_i),
    .fb         (wr_if.master)
  );

  scanout_fetch scanout_fetch_u (
    .HDMI_CLK_w  (HDMI_CLK_w),
    .HDMI_nRST_w (HDMI_nRST_w),
    .scan_en_i   (scan_en_i),
    .credit_ret_i(credit_ret_w),
    .fb          (rd_if.master),
    .pix_push_o  (pix_push_w),
    .pix_o       (pix_w)
  );

  // Timing, pixel FIFO and output registers
  video_timing_out video_timing_out_u (
    .HDMI_CLK_w  (HDMI_CLK_w),
    .HDMI_nRST_w (HDMI_nRST_w),
    .scan_en_i   (scan_en_i),
    .pix_push_i  (pix_push_w),
    .pix_i       (pix_w),
    .credit_ret_o(credit_ret_w),
    .HSYNC_o     (HSYNC_o),
    .VSYNC_o     (VSYNC_o),
    .DE_o        (DE_o),
    .VD_o        (VD_o),
    .underrun_o  (underrun_o)
  );

endmodule

// File: testbench/vout_chk.sv
// Protocol checker for the HDMI video output path
// Idle outputs, sync and DE shape, credit and FIFO limits, underrun
`timescale 1ns/1ps
`include "vout_params.svh"

module vout_chk (
  input logic              HDMI_CLK_w,
  input logic              HDMI_nRST_w,
  input logic              scan_en_i,
  input logic              hsync_i,
  input logic              vsync_i,
  input logic              de_i,
  input vout_pkg::pixel_t  vd_i,
  input logic              underrun_i,
  input vout_pkg::credit_t credits_i,
  input vout_pkg::credit_t fifo_cnt_i,
  input logic              pix_push_i
);

  import vout_pkg::*;

  localparam credit_t DEPTH = credit_t'(`VOUT_FIFO_DEPTH);

  // Failure tallies, one per property
  int unsigned idle_err = 0;
  int unsigned blank_err = 0;
  int unsigned hs_len_err = 0;
  int unsigned hs_per_err = 0;
  int unsigned vs_len_err = 0;
  int unsigned de_len_err = 0;
  int unsigned urun_err = 0;
  int unsigned credit_err = 0;
  int unsigned full_err = 0;
  int unsigned fail_cnt;

  // Run lengths of high samples, and cycles since the last HSYNC rise
  logic [7:0] hs_run;
  logic [7:0] vs_run;
  logic [7:0] de_run;
  logic [7:0] hs_gap;
  logic       hs_seen;

  assign fail_cnt = idle_err + blank_err + hs_len_err + hs_per_err + vs_len_err
                  + de_len_err + urun_err + credit_err + full_err;

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      hs_run  <= '0;
      vs_run  <= '0;
      de_run  <= '0;
      hs_gap  <= '0;
      hs_seen <= 1'b0;
    end else begin
      hs_run <= hsync_i ? hs_run + 1'b1 : '0;
      vs_run <= vsync_i ? vs_run + 1'b1 : '0;
      de_run <= de_i ? de_run + 1'b1 : '0;
      // hs_run of zero means HSYNC was low one sample back
      if (!scan_en_i) begin
        hs_gap  <= '0;
        hs_seen <= 1'b0;
      end else if (hsync_i && hs_run == '0) begin
        hs_gap  <= 8'd1;
        hs_seen <= 1'b1;
      end else if (hs_gap != 8'hff) begin
        hs_gap <= hs_gap + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Idle and blanking

  a_idle: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    !$past(scan_en_i) |-> !hsync_i && !vsync_i && !de_i && !underrun_i)
  else begin
    idle_err++;
    $error("video outputs active while scanout is disabled");
  end

  // No pixel data outside DE
  a_blank: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    !de_i |-> vd_i == '0)
  else begin
    blank_err++;
    $error("VD_o nonzero while DE_o is low");
  end

  ////////////////////////////////////////////////////////////
  // Raster shape

  a_hs_len: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w || !scan_en_i)
    $fell(hsync_i) |-> hs_run == 8'(`VOUT_H_SYNC))
  else begin
    hs_len_err++;
    $error("HSYNC_o pulse width wrong, %0d cycles", hs_run);
  end

  a_hs_per: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w || !scan_en_i)
    hsync_i && hs_run == '0 && hs_seen |-> hs_gap == 8'(`VOUT_H_TOTAL))
  else begin
    hs_per_err++;
    $error("HSYNC_o period wrong, %0d cycles", hs_gap);
  end

  a_vs_len: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w || !scan_en_i)
    $fell(vsync_i) |-> vs_run == 8'(`VOUT_V_SYNC * `VOUT_H_TOTAL))
  else begin
    vs_len_err++;
    $error("VSYNC_o pulse width wrong, %0d cycles", vs_run);
  end

  a_de_len: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w || !scan_en_i)
    $fell(de_i) |-> de_run == 8'(`VOUT_H_ACTIVE))
  else begin
    de_len_err++;
    $error("DE_o run length wrong, %0d cycles", de_run);
  end

  ////////////////////////////////////////////////////////////
  // Flow control

  a_urun: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    !underrun_i)
  else begin
    urun_err++;
    $error("pixel FIFO ran dry during DE");
  end

  a_credit: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    credits_i <= DEPTH)
  else begin
    credit_err++;
    $error("fetch credits above FIFO depth, %0d", credits_i);
  end

  a_full: assert property (@(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    !(pix_push_i && fifo_cnt_i == DEPTH))
  else begin
    full_err++;
    $error("pixel pushed into a full FIFO");
  end

endmodule

bind vout_top vout_chk vout_chk_u (
  .HDMI_CLK_w (HDMI_CLK_w),
  .HDMI_nRST_w(HDMI_nRST_w),
  .scan_en_i  (scan_en_i),
  .hsync_i    (HSYNC_o),
  .vsync_i    (VSYNC_o),
  .de_i       (DE_o),
  .vd_i       (VD_o),
  .underrun_i (underrun_o),
  .credits_i  (scanout_fetch_u.credits_q),
  .fifo_cnt_i (video_timing_out_u.fifo_cnt_q),
  .pix_push_i (pix_push_w)
);

// File: testbench/vout_tb.sv
// Testbench for the HDMI video output path
// Captures tagged frames, runs scanout and compares every active pixel
`timescale 1ns/1ps
`include "vout_params.svh"

module vout_tb;

  localparam int W            = `VOUT_H_ACTIVE;
  localparam int H            = `VOUT_V_ACTIVE;
  localparam int FRAME        = W * H;
  localparam int FRAME_CYCLES = `VOUT_H_TOTAL * `VOUT_V_TOTAL;

  logic        HDMI_CLK_w = 1'b0;
  logic        HDMI_nRST_w;
  logic        scan_en_i;
  logic        cap_valid_i;
  logic        cap_sof_i;
  logic [23:0] cap_pixel_i;
  logic        HSYNC_o;
  logic        VSYNC_o;
  logic        DE_o;
  logic [23:0] VD_o;
  logic        underrun_o;

  integer      seed = 32'haffa;
  int          errors = 0;
  int          timeouts = 0;
  int          checked = 0;
  int          px = 0;
  int          py = 0;
  logic [7:0]  exp_tag = 8'd0;
  logic [23:0] exp_pix;

  // 50 MHz pixel clock
  always #10 HDMI_CLK_w = ~HDMI_CLK_w;

  vout_top vout_top_i (
    .HDMI_CLK_w (HDMI_CLK_w),
    .HDMI_nRST_w(HDMI_nRST_w),
    .scan_en_i  (scan_en_i),
    .cap_valid_i(cap_valid_i),
    .cap_sof_i  (cap_sof_i),
    .cap_pixel_i(cap_pixel_i),
    .HSYNC_o    (HSYNC_o),
    .VSYNC_o    (VSYNC_o),
    .DE_o       (DE_o),
    .VD_o       (VD_o),
    .underrun_o (underrun_o)
  );

  ////////////////////////////////////////////////////////////
  // Pixel compare on the falling edge against our own raster position

  always @(negedge HDMI_CLK_w) begin
    if (!scan_en_i) begin
      px = 0;
      py = 0;
    end else if (DE_o) begin
      exp_pix = {exp_tag, 8'(py), 8'(px)};
      checked++;
      assert (VD_o == exp_pix)
      else begin
        errors++;
        $display("ERROR %0t ns: VD_o expected %h, actual %h", $time, exp_pix, VD_o);
      end
      px++;
      if (px == W) begin
        px = 0;
        py = (py == H - 1) ? 0 : py + 1;
      end
    end else if (VSYNC_o) begin
      // Each frame restarts at row 0 after VSYNC
      px = 0;
      py = 0;
    end
  end

  // One frame in raster order with min_idle to min_idle+3 idle cycles per pixel
  task automatic capture_frame(input logic [7:0] tag, input int min_idle);
    int idle;
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        cap_valid_i <= 1'b1;
        cap_sof_i   <= (x == 0) && (y == 0);
        cap_pixel_i <= {tag, 8'(y), 8'(x)};
        @(posedge HDMI_CLK_w);
        cap_valid_i <= 1'b0;
        cap_sof_i   <= 1'b0;
        idle = min_idle + int'($unsigned($random(seed)) % 4);
        repeat (idle) @(posedge HDMI_CLK_w);
      end
    end
  endtask

  // Until the write queue is empty
  task automatic wait_writer_idle(input int limit);
    int n;
    n = 0;
    @(negedge HDMI_CLK_w);
    while (vout_top_i.wr_if.req && n < limit) begin
      @(negedge HDMI_CLK_w);
      n++;
    end
    if (vout_top_i.wr_if.req) begin
      timeouts++;
      $display("Timeout: capture writer still busy after %0d cycles", limit);
    end
    @(posedge HDMI_CLK_w);
  endtask

  // Until count more active pixels were compared
  task automatic wait_pixels(input int count, input int limit);
    int target;
    int n;
    target = checked + count;
    n = 0;
    while (checked < target && n < limit) begin
      @(posedge HDMI_CLK_w);
      n++;
    end
    if (checked < target) begin
      timeouts++;
      $display("Timeout: only %0d of %0d pixels seen in %0d cycles",
               count - (target - checked), count, limit);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    HDMI_nRST_w = 1'b0;
    scan_en_i   = 1'b0;
    cap_valid_i = 1'b0;
    cap_sof_i   = 1'b0;
    cap_pixel_i = '0;
    repeat (2) @(posedge HDMI_CLK_w);
    HDMI_nRST_w <= 1'b1;

    // Outputs stay quiet with scanout off
    repeat (20) @(posedge HDMI_CLK_w);

    // Tag 1 frame before three frames of scanout
    capture_frame(8'd1, 1);
    wait_writer_idle(20);
    exp_tag = 8'd1;
    scan_en_i <= 1'b1;
    wait_pixels(3 * FRAME, 5 * FRAME_CYCLES);

    // Same frame rewritten during scanout so writer and fetcher contend
    capture_frame(8'd1, 2);
    wait_writer_idle(20);
    wait_pixels(FRAME, 3 * FRAME_CYCLES);

    // Tag 2 captured while off must show in the first frame after enable
    scan_en_i <= 1'b0;
    @(posedge HDMI_CLK_w);
    // Stray pixels leave the write address past word 0 for the sof reset to undo
    for (int i = 0; i < 3; i++) begin
      cap_valid_i <= 1'b1;
      cap_pixel_i <= {8'hee, 8'h00, 8'(i)};
      @(posedge HDMI_CLK_w);
      cap_valid_i <= 1'b0;
      @(posedge HDMI_CLK_w);
    end
    capture_frame(8'd2, 1);
    wait_writer_idle(20);
    exp_tag = 8'd2;
    scan_en_i <= 1'b1;
    wait_pixels(2 * FRAME, 4 * FRAME_CYCLES);

    scan_en_i <= 1'b0;
    repeat (2) @(posedge HDMI_CLK_w);
    $display("pixels checked %0d, pixel errors %0d, assertion failures %0d, timeouts %0d",
             checked, errors, vout_top_i.vout_chk_u.fail_cnt, timeouts);
    if (errors == 0 && timeouts == 0 && vout_top_i.vout_chk_u.fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
